// File: source/hist_cfg_pkg.sv
package hist_cfg_pkg;

    // width of one stored bin count
    localparam int COUNT_W = 16;

    // default geometry, overridden from the top level
    localparam int DEF_BIN_NUM = 8;
    localparam int DEF_PIXEL_NUM = 4;
    localparam int DEF_EVENTS_PER_PIXEL = 6;
    localparam int DEF_ACQ_NUM = 3;

    typedef logic [COUNT_W-1:0] count_t;

    // builder FSM
    typedef enum logic [2:0] {
        ST_ACCEPT,
        ST_RD_WAIT,
        ST_WRITE,
        ST_HOLD,
        ST_CLEAR
    } builder_state_e;

endpackage

// File: source/hist_bus_pkg.sv
package hist_bus_pkg;

    // AXI4-Lite byte address and data widths
    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;

    // word address width inside one RAM bank, sized for the largest geometry
    localparam int RAM_ADDR_W = 12;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_DATA_W/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_e resp;
    } axil_r_t;

    // one RAM access, write flag set for writes
    typedef struct packed {
        logic wr;
        logic bank;
        logic [RAM_ADDR_W-1:0] addr;
        hist_cfg_pkg::count_t count;
    } ram_req_t;

    // read data, valid one cycle after the granted read
    typedef struct packed {
        hist_cfg_pkg::count_t count;
        logic valid;
    } ram_rsp_t;

endpackage

// File: source/hist_builder.sv
`timescale 1ns/1ps

module hist_builder #(
    parameter int BIN_NUM = hist_cfg_pkg::DEF_BIN_NUM,
    parameter int PIXEL_NUM = hist_cfg_pkg::DEF_PIXEL_NUM,
    parameter int EVENTS_PER_PIXEL = hist_cfg_pkg::DEF_EVENTS_PER_PIXEL,
    parameter int ACQ_NUM = hist_cfg_pkg::DEF_ACQ_NUM
) (
    input  logic clk,
    input  logic res,
    input  logic event_valid,
    input  logic [$clog2(BIN_NUM)-1:0] event_bin,
    output logic event_ready,
    input  logic frame_ack,
    output logic req_valid,
    output hist_bus_pkg::ram_req_t req,
    input  logic grant,
    input  hist_bus_pkg::ram_rsp_t rsp,
    output logic frame_ready,
    output logic [7:0] frame_count,
    output logic ready_bank
);
    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    localparam int WORDS = BIN_NUM * PIXEL_NUM;
    localparam int EV_W = $clog2(EVENTS_PER_PIXEL + 1);
    localparam int PX_W = $clog2(PIXEL_NUM + 1);
    localparam int AQ_W = $clog2(ACQ_NUM + 1);

    builder_state_e state;
    logic [EV_W-1:0] ev_cnt;
    logic [PX_W-1:0] px_cnt;
    logic [AQ_W-1:0] aq_cnt;
    logic [RAM_ADDR_W-1:0] clr_addr;
    logic [RAM_ADDR_W-1:0] bin_addr;
    logic [$clog2(BIN_NUM)-1:0] bin_q;
    logic rd_sent;
    logic ev_last;
    logic px_last;
    logic aq_last;
    count_t wr_count;

    assign ev_last = ev_cnt == EV_W'(EVENTS_PER_PIXEL - 1);
    assign px_last = px_cnt == PX_W'(PIXEL_NUM - 1);
    assign aq_last = aq_cnt == AQ_W'(ACQ_NUM - 1);

    // word of the current pixel's histogram
    assign bin_addr = RAM_ADDR_W'(px_cnt * BIN_NUM + bin_q);

    assign event_ready = state == ST_ACCEPT;
    assign req_valid = (state == ST_RD_WAIT && !rd_sent) || state == ST_WRITE
                       || state == ST_CLEAR;

    // always fills the bank the host is not reading
    always_comb begin
        req.wr = state != ST_RD_WAIT;
        req.bank = ~ready_bank;
        req.addr = (state == ST_CLEAR) ? clr_addr : bin_addr;
        req.count = (state == ST_CLEAR) ? '0 : wr_count;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // bank 0 gets cleared first
            state <= ST_CLEAR;
            ev_cnt <= '0;
            px_cnt <= '0;
            aq_cnt <= '0;
            clr_addr <= '0;
            rd_sent <= 1'b0;
            frame_ready <= 1'b0;
            frame_count <= '0;
            ready_bank <= 1'b1;
        end else begin
            // an ack in hold is used up by the older frame
            if (frame_ack && state != ST_HOLD) begin
                frame_ready <= 1'b0;
            end
            case (state)
                ST_ACCEPT: begin
                    if (event_valid) begin
                        state <= ST_RD_WAIT;
                    end
                end
                ST_RD_WAIT: begin
                    if (grant) begin
                        rd_sent <= 1'b1;
                    end
                    if (rsp.valid) begin
                        rd_sent <= 1'b0;
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (grant) begin
                        state <= ST_ACCEPT;
                        ev_cnt <= ev_cnt + 1'b1;
                        if (ev_last) begin
                            ev_cnt <= '0;
                            px_cnt <= px_cnt + 1'b1;
                            if (px_last) begin
                                px_cnt <= '0;
                                aq_cnt <= aq_cnt + 1'b1;
                                if (aq_last) begin
                                    // frame done, swap banks
                                    aq_cnt <= '0;
                                    ready_bank <= ~ready_bank;
                                    frame_count <= frame_count + 1'b1;
                                    frame_ready <= 1'b1;
                                    // previous frame still unread
                                    if (frame_ready && !frame_ack) begin
                                        state <= ST_HOLD;
                                    end else begin
                                        state <= ST_CLEAR;
                                    end
                                end
                            end
                        end
                    end
                end
                ST_HOLD: begin
                    if (frame_ack) begin
                        state <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    // one zero word per grant
                    if (grant) begin
                        if (clr_addr == RAM_ADDR_W'(WORDS - 1)) begin
                            clr_addr <= '0;
                            state <= ST_ACCEPT;
                        end else begin
                            clr_addr <= clr_addr + 1'b1;
                        end
                    end
                end
                default: state <= ST_CLEAR;
            endcase
        end
    end

    // event bin and incremented count
    always_ff @(posedge clk) begin
        if (event_valid && event_ready) begin
            bin_q <= event_bin;
        end
        if (state == ST_RD_WAIT && rsp.valid) begin
            wr_count <= rsp.count + 1'b1;
        end
    end

endmodule

// File: source/hist_ram_arbiter.sv
`timescale 1ns/1ps

module hist_ram_arbiter (
    input  logic clk,
    input  logic res,
    input  logic b_valid,
    input  hist_bus_pkg::ram_req_t b_req,
    output logic b_grant,
    output hist_bus_pkg::ram_rsp_t b_rsp,
    input  logic r_valid,
    input  hist_bus_pkg::ram_req_t r_req,
    output logic r_grant,
    output hist_bus_pkg::ram_rsp_t r_rsp,
    output logic mem_valid,
    output hist_bus_pkg::ram_req_t mem_req,
    input  hist_bus_pkg::ram_rsp_t mem_rsp
);

    // builder won the last grant
    logic last_b;
    // builder owns the read in flight
    logic owner_b;

    // builder loses a tie only right after its own grant
    assign b_grant = b_valid && (!r_valid || !last_b);
    assign r_grant = r_valid && !b_grant;

    assign mem_valid = b_valid || r_valid;
    assign mem_req = b_grant ? b_req : r_req;

    // data goes to both, valid only to the owner
    always_comb begin
        b_rsp = mem_rsp;
        b_rsp.valid = mem_rsp.valid && owner_b;
        r_rsp = mem_rsp;
        r_rsp.valid = mem_rsp.valid && !owner_b;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            last_b <= 1'b0;
            owner_b <= 1'b0;
        end else if (mem_valid) begin
            last_b <= b_grant;
            if (!mem_req.wr) begin
                owner_b <= b_grant;
            end
        end
    end

endmodule

// File: source/hist_ram.sv
`timescale 1ns/1ps

module hist_ram #(
    parameter int BIN_NUM = hist_cfg_pkg::DEF_BIN_NUM,
    parameter int PIXEL_NUM = hist_cfg_pkg::DEF_PIXEL_NUM
) (
    input  logic clk,
    input  logic mem_valid,
    input  hist_bus_pkg::ram_req_t mem_req,
    output hist_bus_pkg::ram_rsp_t mem_rsp
);
    import hist_cfg_pkg::*;

    localparam int WORDS = BIN_NUM * PIXEL_NUM;

    // bank 1 sits above bank 0
    count_t mem [2*WORDS];
    int idx;

    assign idx = (mem_req.bank ? WORDS : 0) + int'(mem_req.addr);

    always_ff @(posedge clk) begin
        mem_rsp.valid <= mem_valid && !mem_req.wr;
        if (mem_valid) begin
            if (mem_req.wr) begin
                mem[idx] <= mem_req.count;
            end else begin
                mem_rsp.count <= mem[idx];
            end
        end
    end

endmodule

// File: source/hist_axil_readout.sv
`timescale 1ns/1ps

module hist_axil_readout #(
    parameter int BIN_NUM = hist_cfg_pkg::DEF_BIN_NUM,
    parameter int PIXEL_NUM = hist_cfg_pkg::DEF_PIXEL_NUM
) (
    input  logic clk,
    input  logic res,
    input  hist_bus_pkg::axil_aw_t aw,
    input  logic awvalid,
    output logic awready,
    input  hist_bus_pkg::axil_w_t w,
    input  logic wvalid,
    output logic wready,
    output hist_bus_pkg::axil_b_t b,
    output logic bvalid,
    input  logic bready,
    input  hist_bus_pkg::axil_ar_t ar,
    input  logic arvalid,
    output logic arready,
    output hist_bus_pkg::axil_r_t r,
    output logic rvalid,
    input  logic rready,
    input  logic frame_ready,
    input  logic [7:0] frame_count,
    input  logic ready_bank,
    output logic frame_ack,
    output logic req_valid,
    output hist_bus_pkg::ram_req_t req,
    input  logic grant,
    input  hist_bus_pkg::ram_rsp_t rsp
);
    import hist_bus_pkg::*;

    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 'h000;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_ACK = 'h004;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_BINS = 'h100;
    localparam logic [AXIL_ADDR_W-3:0] WORDS = (AXIL_ADDR_W-2)'(BIN_NUM * PIXEL_NUM);

    logic wr_take;
    logic rd_take;
    logic rd_pend;
    logic rd_wait;
    logic is_bin;
    logic [AXIL_ADDR_W-1:0] rd_addr;
    logic [AXIL_ADDR_W-3:0] word;
    logic [AXIL_DATA_W-1:0] status;

    // AW and W only together, none while B is pending
    assign wr_take = awvalid && wvalid && !bvalid;
    assign awready = wr_take;
    assign wready = wr_take;

    // one read in flight at a time
    assign rd_take = arvalid && !rd_pend && !rvalid;
    assign arready = rd_take;

    // word index into the ready bank
    assign word = rd_addr[AXIL_ADDR_W-1:2] - ADDR_BINS[AXIL_ADDR_W-1:2];
    assign is_bin = rd_addr >= ADDR_BINS && word < WORDS;
    assign status = {16'h0, frame_count, 6'h0, ready_bank, frame_ready};

    assign req_valid = rd_pend && is_bin && !rd_wait;

    always_comb begin
        req.wr = 1'b0;
        req.bank = ready_bank;
        req.addr = RAM_ADDR_W'(word);
        req.count = '0;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bvalid <= 1'b0;
            frame_ack <= 1'b0;
            rd_pend <= 1'b0;
            rd_wait <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            // one-cycle pulse, write data ignored
            frame_ack <= wr_take && aw.addr == ADDR_ACK;
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_take) begin
                rd_pend <= 1'b1;
            end else if (rd_pend) begin
                // local registers answer at once
                if (!is_bin || rsp.valid) begin
                    rd_pend <= 1'b0;
                    rd_wait <= 1'b0;
                    rvalid <= 1'b1;
                end else if (grant) begin
                    rd_wait <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            b.resp <= (aw.addr == ADDR_ACK) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_take) begin
            rd_addr <= ar.addr;
        end
        // unmapped reads give zero
        if (rd_pend) begin
            r.resp <= RESP_OKAY;
            if (is_bin) begin
                r.data <= AXIL_DATA_W'(rsp.count);
            end else if (rd_addr == ADDR_STATUS) begin
                r.data <= status;
            end else begin
                r.data <= '0;
            end
        end
    end

endmodule

// File: source/hist_top.sv
`timescale 1ns/1ps

module hist_top #(
    parameter int BIN_NUM = hist_cfg_pkg::DEF_BIN_NUM,
    parameter int PIXEL_NUM = hist_cfg_pkg::DEF_PIXEL_NUM,
    parameter int EVENTS_PER_PIXEL = hist_cfg_pkg::DEF_EVENTS_PER_PIXEL,
    parameter int ACQ_NUM = hist_cfg_pkg::DEF_ACQ_NUM
) (
    input  logic clk,
    input  logic res,
    input  logic event_valid,
    input  logic [$clog2(BIN_NUM)-1:0] event_bin,
    output logic event_ready,
    input  hist_bus_pkg::axil_aw_t aw,
    input  logic awvalid,
    output logic awready,
    input  hist_bus_pkg::axil_w_t w,
    input  logic wvalid,
    output logic wready,
    output hist_bus_pkg::axil_b_t b,
    output logic bvalid,
    input  logic bready,
    input  hist_bus_pkg::axil_ar_t ar,
    input  logic arvalid,
    output logic arready,
    output hist_bus_pkg::axil_r_t r,
    output logic rvalid,
    input  logic rready
);
    import hist_bus_pkg::*;

    // builder side of the arbiter
    logic b_valid;
    logic b_grant;
    ram_req_t b_req;
    ram_rsp_t b_rsp;
    // readout side
    logic r_valid;
    logic r_grant;
    ram_req_t r_req;
    ram_rsp_t r_rsp;
    // RAM port
    logic mem_valid;
    ram_req_t mem_req;
    ram_rsp_t mem_rsp;
    // frame hand-over
    logic frame_ready;
    logic frame_ack;
    logic ready_bank;
    logic [7:0] frame_count;

    hist_builder #(
        .BIN_NUM(BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQ_NUM(ACQ_NUM)
    ) i_builder (
        .clk(clk),
        .res(res),
        .event_valid(event_valid),
        .event_bin(event_bin),
        .event_ready(event_ready),
        .frame_ack(frame_ack),
        .req_valid(b_valid),
        .req(b_req),
        .grant(b_grant),
        .rsp(b_rsp),
        .frame_ready(frame_ready),
        .frame_count(frame_count),
        .ready_bank(ready_bank)
    );

    hist_axil_readout #(
        .BIN_NUM(BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM)
    ) i_readout (
        .clk(clk),
        .res(res),
        .aw(aw),
        .awvalid(awvalid),
        .awready(awready),
        .w(w),
        .wvalid(wvalid),
        .wready(wready),
        .b(b),
        .bvalid(bvalid),
        .bready(bready),
        .ar(ar),
        .arvalid(arvalid),
        .arready(arready),
        .r(r),
        .rvalid(rvalid),
        .rready(rready),
        .frame_ready(frame_ready),
        .frame_count(frame_count),
        .ready_bank(ready_bank),
        .frame_ack(frame_ack),
        .req_valid(r_valid),
        .req(r_req),
        .grant(r_grant),
        .rsp(r_rsp)
    );

    hist_ram_arbiter i_arbiter (
        .clk(clk),
        .res(res),
        .b_valid(b_valid),
        .b_req(b_req),
        .b_grant(b_grant),
        .b_rsp(b_rsp),
        .r_valid(r_valid),
        .r_req(r_req),
        .r_grant(r_grant),
        .r_rsp(r_rsp),
        .mem_valid(mem_valid),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    hist_ram #(
        .BIN_NUM(BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM)
    ) i_ram (
        .clk(clk),
        .mem_valid(mem_valid),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic res
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset low for 3 rising edges
    initial begin
        res = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        res = 1'b1;
    end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int BIN_NUM = 8,
    parameter int PIXEL_NUM = 4,
    parameter int EVENTS_PER_PIXEL = 6,
    parameter int ACQ_NUM = 3
) (
    input  logic clk,
    input  logic res,
    input  logic event_valid,
    input  logic [$clog2(BIN_NUM)-1:0] event_bin,
    input  logic event_ready,
    input  hist_bus_pkg::axil_aw_t aw,
    input  logic awvalid,
    input  logic awready,
    input  logic wready,
    input  hist_bus_pkg::axil_b_t b,
    input  logic bvalid,
    input  logic bready,
    input  hist_bus_pkg::axil_ar_t ar,
    input  logic arvalid,
    input  logic arready,
    input  hist_bus_pkg::axil_r_t r,
    input  logic rvalid,
    input  logic rready,
    input  logic skip_r,
    output int errors
);
    import hist_bus_pkg::*;

    localparam int WORDS = BIN_NUM * PIXEL_NUM;

    // set from the testbench top for error lines
    string test_name = "reset";

    // model banks, fill is the bank being counted into
    logic [15:0] model [2][WORDS];
    int ev;
    int px;
    int aq;
    logic fill;
    logic frame_ready_m;
    // frame done while the older one was unacknowledged
    logic hold_m;
    logic [7:0] count_m;
    logic [31:0] exp_r;
    logic skip_q;
    axil_resp_e exp_b;

    // read data as the address map defines it
    function automatic logic [31:0] expect_read(input logic [15:0] addr);
        int word;
        word = (int'(addr) - 256) / 4;
        if (addr == 16'h0) begin
            return {16'h0, count_m, 6'h0, ~fill, frame_ready_m};
        end
        if (addr >= 16'h100 && word < WORDS) begin
            return {16'h0, model[~fill][word]};
        end
        return 32'h0;
    endfunction

    always @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < WORDS; i++) begin
                model[0][i] = '0;
                model[1][i] = '0;
            end
            ev = 0;
            px = 0;
            aq = 0;
            fill = 1'b0;
            frame_ready_m = 1'b0;
            hold_m = 1'b0;
            count_m = '0;
            errors = 0;
        end else begin
            if (event_valid && event_ready) begin
                if (hold_m) begin
                    errors++;
                    $display("Error in %s: event accepted while the frame was held",
                             test_name);
                end
                model[fill][px * BIN_NUM + int'(event_bin)]++;
                ev++;
                if (ev == EVENTS_PER_PIXEL) begin
                    ev = 0;
                    px++;
                end
                if (px == PIXEL_NUM) begin
                    px = 0;
                    aq++;
                end
                // frame end, new fill bank starts at zero
                if (aq == ACQ_NUM) begin
                    aq = 0;
                    hold_m = frame_ready_m;
                    frame_ready_m = 1'b1;
                    count_m++;
                    fill = ~fill;
                    for (int i = 0; i < WORDS; i++) begin
                        model[fill][i] = '0;
                    end
                end
            end
            // AW and W go in together
            if (awready != wready) begin
                errors++;
                $display("Error in %s: wready expected %0b actual %0b",
                         test_name, awready, wready);
            end
            if (awvalid && awready) begin
                exp_b = (aw.addr == 16'h4) ? RESP_OKAY : RESP_SLVERR;
                // ack in hold only releases the builder
                if (aw.addr == 16'h4) begin
                    if (hold_m) begin
                        hold_m = 1'b0;
                    end else begin
                        frame_ready_m = 1'b0;
                    end
                end
            end
            if (bvalid && bready && b.resp != exp_b) begin
                errors++;
                $display("Error in %s: bresp expected %0d actual %0d",
                         test_name, exp_b, b.resp);
            end
            if (arvalid && arready) begin
                exp_r = expect_read(ar.addr);
                skip_q = skip_r;
            end
            if (rvalid && rready && !skip_q) begin
                if (r.data != exp_r || r.resp != RESP_OKAY) begin
                    errors++;
                    $display("Error in %s: rdata expected %h actual %h (resp %0d)",
                             test_name, exp_r, r.data, r.resp);
                end
            end
        end
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import hist_bus_pkg::*;

    localparam int BIN_NUM = 8;
    localparam int PIXEL_NUM = 4;
    localparam int EVENTS_PER_PIXEL = 6;
    localparam int ACQ_NUM = 3;
    // four frames of events plus reads, polls and writes
    localparam int EVENT_NUM = 4 * EVENTS_PER_PIXEL * PIXEL_NUM * ACQ_NUM;
    localparam int AXI_NUM = 200;
    localparam int LIMIT = (EVENT_NUM * 40 + AXI_NUM * 20) * 2;

    logic clk;
    logic res;
    logic event_valid;
    logic [2:0] event_bin;
    logic event_ready;
    axil_aw_t aw;
    logic awvalid;
    logic awready;
    axil_w_t w;
    logic wvalid;
    logic wready;
    axil_b_t b;
    logic bvalid;
    logic bready;
    axil_ar_t ar;
    logic arvalid;
    logic arready;
    axil_r_t r;
    logic rvalid;
    logic rready;
    logic skip_r;
    int errors;
    int cycles = 0;
    integer seed = 32'h9064;
    integer host_seed;
    logic [31:0] d;

    tb_clock_gen i_clock (
        .clk(clk),
        .res(res)
    );

    hist_top #(
        .BIN_NUM(BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQ_NUM(ACQ_NUM)
    ) i_dut (
        .clk(clk), .res(res),
        .event_valid(event_valid), .event_bin(event_bin), .event_ready(event_ready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

    tb_checker #(
        .BIN_NUM(BIN_NUM),
        .PIXEL_NUM(PIXEL_NUM),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQ_NUM(ACQ_NUM)
    ) i_checker (
        .clk(clk), .res(res),
        .event_valid(event_valid), .event_bin(event_bin), .event_ready(event_ready),
        .aw(aw), .awvalid(awvalid), .awready(awready), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .skip_r(skip_r), .errors(errors)
    );

    task automatic offer_event();
        event_bin = 3'($random(seed));
        event_valid = 1'b1;
    endtask

    // holds valid until the handshake edge
    task automatic wait_taken();
        @(posedge clk);
        while (!event_ready) @(posedge clk);
        #1;
        event_valid = 1'b0;
    endtask

    task automatic send_events(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = int'($unsigned($random(seed)) % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            offer_event();
            wait_taken();
        end
    endtask

    // slow lets rready drop for random cycles
    task automatic axi_read(input logic [15:0] addr, input bit check, input bit slow,
                            output logic [31:0] data);
        skip_r = !check;
        ar.addr = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready = slow ? 1'($random(host_seed)) : 1'b1;
        @(posedge clk);
        while (!(rvalid && rready)) begin
            #1;
            if (slow) rready = 1'($random(host_seed));
            @(posedge clk);
        end
        data = r.data;
        #1;
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [15:0] addr, input bit slow);
        aw.addr = addr;
        w.data = $random(host_seed);
        w.strb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = slow ? 1'($random(host_seed)) : 1'b1;
        @(posedge clk);
        while (!(bvalid && bready)) begin
            #1;
            if (slow) bready = 1'($random(host_seed));
            @(posedge clk);
        end
        #1;
        bready = 1'b0;
    endtask

    // status polls are not compared, the swap lags the last event
    task automatic wait_frame_count(input logic [7:0] n);
        logic [31:0] s;
        s = '0;
        do begin
            axi_read(16'h0, 1'b0, 1'b0, s);
        end while (s[15:8] != n);
    endtask

    task automatic read_bins();
        logic [31:0] v;
        for (int i = 0; i < BIN_NUM * PIXEL_NUM; i++) begin
            axi_read(16'(256 + 4 * i), 1'b1, 1'b0, v);
        end
    endtask

    task automatic host_traffic();
        logic [31:0] v;
        int word;
        for (int i = 0; i < 40; i++) begin
            word = int'($unsigned($random(host_seed)) % (BIN_NUM * PIXEL_NUM));
            axi_read(16'(256 + 4 * word), 1'b1, 1'b1, v);
            if (i % 10 == 9) axi_write(16'h200, 1'b1);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        // host side draws from its own stream
        host_seed = $random(seed);
        event_valid = 1'b0;
        event_bin = '0;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        ar = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        skip_r = 1'b0;
        @(posedge res);
        @(posedge clk);
        #1;

        i_checker.test_name = "after_reset";
        axi_read(16'h0, 1'b1, 1'b0, d);
        axi_write(16'h200, 1'b0);
        axi_read(16'h80, 1'b1, 1'b0, d);

        i_checker.test_name = "first_frame";
        send_events(72);
        wait_frame_count(8'd1);
        axi_read(16'h0, 1'b1, 1'b0, d);
        read_bins();

        // second frame counted with the first still unacknowledged
        i_checker.test_name = "frame_hold";
        send_events(72);
        wait_frame_count(8'd2);
        offer_event();
        axi_read(16'h0, 1'b1, 1'b0, d);
        axi_read(16'h0, 1'b1, 1'b0, d);
        // longer than one clear sweep so a skipped hold takes the event here
        repeat (2 * BIN_NUM * PIXEL_NUM) begin
            @(posedge clk);
            #1;
        end
        axi_write(16'h4, 1'b0);
        wait_taken();

        i_checker.test_name = "clean_bank";
        send_events(71);
        wait_frame_count(8'd3);
        axi_read(16'h0, 1'b1, 1'b0, d);
        read_bins();
        axi_write(16'h4, 1'b0);

        // last event held back so the ready bank stays put
        i_checker.test_name = "contention";
        fork
            send_events(71);
            host_traffic();
        join
        send_events(1);
        wait_frame_count(8'd4);
        axi_read(16'h0, 1'b1, 1'b0, d);
        read_bins();
        axi_write(16'h4, 1'b0);

        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/hist_cfg_pkg.sv
source/hist_bus_pkg.sv
source/hist_builder.sv
source/hist_ram_arbiter.sv
source/hist_ram.sv
source/hist_axil_readout.sv
source/hist_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Makefile
SIM      = verilator
TOP      = tb_top
FILELIST = files.f
FLAGS    = --binary --timing -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
